// ==== design/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// ============================================================
// Bus and datapath widths
// ============================================================

`define CORE_ADDR_W     20
`define CORE_WORD_W     16
`define CORE_FLAGS_W    12

// Fixed segment bases, shifted left by 4 on the bus
`define CORE_RESET_CS   16'hF000
`define CORE_RESET_DS   16'h0000

// ============================================================
// Flag bit positions in the flags word
// ============================================================

`define CORE_FLAG_CF    0
`define CORE_FLAG_PF    2
`define CORE_FLAG_AF    4
`define CORE_FLAG_ZF    6
`define CORE_FLAG_SF    7
`define CORE_FLAG_OF    11

`endif

// ==== design/core_pkg.sv ====
package core_pkg;

    // Sequencer modes
    typedef enum logic [2:0] {
        PREPARE,
        MAIN,
        FETCH_MODRM,
        IMMEDIATE,
        STORE,
        WRITEBACK
    } mode_t;

    // Same order as opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_OR,
        ALU_ADC,
        ALU_SBB,
        ALU_AND,
        ALU_SUB,
        ALU_XOR,
        ALU_CMP
    } alu_op_t;

    // Flags register updates
    typedef enum logic [2:0] {
        FLAG_NONE,
        FLAG_ALL,
        FLAG_NO_CF,
        FLAG_CMC,
        FLAG_CLC,
        FLAG_STC
    } flag_op_t;

endpackage

// ==== design/core_alu.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_alu (
    input  logic [`CORE_WORD_W-1:0]  a,
    input  logic [`CORE_WORD_W-1:0]  b,
    input  core_pkg::alu_op_t        op,
    input  logic                     wide,
    input  logic                     carry_in,
    output logic [`CORE_WORD_W-1:0]  result,
    output logic [`CORE_FLAGS_W-1:0] flags_result
);
    import core_pkg::*;

    logic [`CORE_WORD_W-1:0] opa;
    logic [`CORE_WORD_W-1:0] opb;
    logic [`CORE_WORD_W:0]   sum;
    logic [`CORE_WORD_W:0]   diff;
    logic [`CORE_WORD_W:0]   raw;
    logic                    cin;
    logic                    is_sub;
    logic                    is_logic;
    logic                    sa;
    logic                    sb;
    logic                    sr;

    always_comb begin
        // Byte ops work on zero extended operands
        opa = wide ? a : {8'h00, a[7:0]};
        opb = wide ? b : {8'h00, b[7:0]};
        cin = (op == ALU_ADC || op == ALU_SBB) ? carry_in : 1'b0;
        sum  = {1'b0, opa} + {1'b0, opb} + {16'd0, cin};
        diff = {1'b0, opa} - {1'b0, opb} - {16'd0, cin};
        is_sub   = (op == ALU_SBB) || (op == ALU_SUB) || (op == ALU_CMP);
        is_logic = (op == ALU_OR) || (op == ALU_AND) || (op == ALU_XOR);

        case (op)
            ALU_ADD, ALU_ADC: raw = sum;
            ALU_OR:           raw = {1'b0, opa | opb};
            ALU_AND:          raw = {1'b0, opa & opb};
            ALU_XOR:          raw = {1'b0, opa ^ opb};
            default:          raw = diff;
        endcase

        result = wide ? raw[15:0] : {8'h00, raw[7:0]};
        sa = wide ? opa[15] : opa[7];
        sb = wide ? opb[15] : opb[7];
        sr = wide ? raw[15] : raw[7];

        flags_result = '0;
        if (!is_logic) begin
            // Carry out of bit 8 or 16 doubles as borrow
            flags_result[`CORE_FLAG_CF] = wide ? raw[16] : raw[8];
            flags_result[`CORE_FLAG_AF] = opa[4] ^ opb[4] ^ raw[4];
            flags_result[`CORE_FLAG_OF] = is_sub ? (sa != sb) && (sr != sa)
                                                 : (sa == sb) && (sr != sa);
        end
        flags_result[`CORE_FLAG_ZF] = (result == '0);
        flags_result[`CORE_FLAG_SF] = sr;
        flags_result[`CORE_FLAG_PF] = ~^raw[7:0];
    end

endmodule

// ==== design/core_regfile.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_regfile (
    input  logic                    clock,
    input  logic                    resetn,
    input  logic                    locked,
    input  logic [2:0]              rsel_a,
    input  logic [2:0]              rsel_b,
    input  logic [2:0]              wsel,
    input  logic                    wide,
    input  logic                    we,
    input  logic [`CORE_WORD_W-1:0] wdata,
    output logic [`CORE_WORD_W-1:0] rdata_a,
    output logic [`CORE_WORD_W-1:0] rdata_b
);

    // AX CX DX BX SP BP SI DI
    logic [`CORE_WORD_W-1:0] regs [0:7];

    // Byte selects 4..7 are the high halves of AX..BX
    function automatic logic [`CORE_WORD_W-1:0] lane(
        input logic [`CORE_WORD_W-1:0] full,
        input logic [`CORE_WORD_W-1:0] base,
        input logic                    high,
        input logic                    wide_acc
    );
        if (wide_acc) begin
            lane = full;
        end else if (high) begin
            lane = {8'h00, base[15:8]};
        end else begin
            lane = {8'h00, base[7:0]};
        end
    endfunction

    always_comb begin
        rdata_a = lane(regs[rsel_a], regs[{1'b0, rsel_a[1:0]}], rsel_a[2], wide);
        rdata_b = lane(regs[rsel_b], regs[{1'b0, rsel_b[1:0]}], rsel_b[2], wide);
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (locked && we) begin
            if (wide) begin
                regs[wsel] <= wdata;
            end else if (wsel[2]) begin
                regs[{1'b0, wsel[1:0]}][15:8] <= wdata[7:0];
            end else begin
                regs[{1'b0, wsel[1:0]}][7:0] <= wdata[7:0];
            end
        end
    end

endmodule

// ==== design/core_flags.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_flags (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     locked,
    input  core_pkg::flag_op_t       flag_op,
    input  logic [`CORE_FLAGS_W-1:0] flags_result,
    input  logic [3:0]               cond,
    output logic [`CORE_FLAGS_W-1:0] flags,
    output logic                     cond_true
);
    import core_pkg::*;

    localparam logic [`CORE_FLAGS_W-1:0] NO_CF_MASK =
        (12'd1 << `CORE_FLAG_PF) | (12'd1 << `CORE_FLAG_AF) | (12'd1 << `CORE_FLAG_ZF) |
        (12'd1 << `CORE_FLAG_SF) | (12'd1 << `CORE_FLAG_OF);
    localparam logic [`CORE_FLAGS_W-1:0] ARITH_MASK = NO_CF_MASK | (12'd1 << `CORE_FLAG_CF);

    logic base;
    logic less;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            flags <= '0;
        end else if (locked) begin
            case (flag_op)
                FLAG_ALL:   flags <= (flags & ~ARITH_MASK) | (flags_result & ARITH_MASK);
                FLAG_NO_CF: flags <= (flags & ~NO_CF_MASK) | (flags_result & NO_CF_MASK);
                FLAG_CMC:   flags[`CORE_FLAG_CF] <= ~flags[`CORE_FLAG_CF];
                FLAG_CLC:   flags[`CORE_FLAG_CF] <= 1'b0;
                FLAG_STC:   flags[`CORE_FLAG_CF] <= 1'b1;
                default: ;
            endcase
        end
    end

    // O C Z BE S P L LE, bit 0 negates
    always_comb begin
        less = flags[`CORE_FLAG_SF] ^ flags[`CORE_FLAG_OF];
        case (cond[3:1])
            3'd0:    base = flags[`CORE_FLAG_OF];
            3'd1:    base = flags[`CORE_FLAG_CF];
            3'd2:    base = flags[`CORE_FLAG_ZF];
            3'd3:    base = flags[`CORE_FLAG_CF] | flags[`CORE_FLAG_ZF];
            3'd4:    base = flags[`CORE_FLAG_SF];
            3'd5:    base = flags[`CORE_FLAG_PF];
            3'd6:    base = less;
            default: base = less | flags[`CORE_FLAG_ZF];
        endcase
        cond_true = base ^ cond[0];
    end

endmodule

// ==== design/core_sequencer.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_sequencer (
    input  logic                    clock,
    input  logic                    resetn,
    input  logic                    locked,
    input  logic [7:0]              bus,
    output logic [`CORE_ADDR_W-1:0] address,
    output logic [7:0]              data,
    output logic                    wreq,
    output logic [2:0]              rsel_a,
    output logic [2:0]              rsel_b,
    output logic [2:0]              wsel,
    output logic                    wide,
    output logic                    we,
    output logic [`CORE_WORD_W-1:0] wdata,
    input  logic [`CORE_WORD_W-1:0] rdata_a,
    input  logic [`CORE_WORD_W-1:0] rdata_b,
    output logic [`CORE_WORD_W-1:0] alu_a,
    output logic [`CORE_WORD_W-1:0] alu_b,
    output core_pkg::alu_op_t       alu_op,
    input  logic [`CORE_WORD_W-1:0] alu_result,
    output core_pkg::flag_op_t      flag_op,
    output logic [3:0]              cond,
    input  logic                    cond_true
);
    import core_pkg::*;

    localparam logic [7:0] OP_HLT = 8'hF4;

    mode_t                   mode;
    logic                    step;
    logic [`CORE_WORD_W-1:0] ip;
    logic [`CORE_WORD_W-1:0] imm;
    logic [7:0]              opcode;
    logic [7:0]              modrm;

    logic                    is_alu_rm;
    logic                    is_alu_imm;
    logic                    is_incdec;
    logic                    is_mov_imm;
    logic                    is_store;
    logic                    is_jcc;
    logic                    is_jmp;
    logic                    is_cmc;
    logic                    is_clc_stc;
    logic                    imm_wide;
    logic [2:0]              dst_sel;
    logic [2:0]              src_sel;
    logic [`CORE_WORD_W-1:0] jump_ip;

    // ============================================================
    // Opcode decode
    // ============================================================

    always_comb begin
        is_alu_rm  = 1'b0;
        is_alu_imm = 1'b0;
        is_incdec  = 1'b0;
        is_mov_imm = 1'b0;
        is_store   = 1'b0;
        is_jcc     = 1'b0;
        is_jmp     = 1'b0;
        is_cmc     = 1'b0;
        is_clc_stc = 1'b0;
        casez (opcode)
            8'b00_???_0??: is_alu_rm  = 1'b1;
            8'b00_???_10?: is_alu_imm = 1'b1;
            8'b0100_????:  is_incdec  = 1'b1;
            8'b1011_????:  is_mov_imm = 1'b1;
            8'b1010_001?:  is_store   = 1'b1;
            8'b0111_????:  is_jcc     = 1'b1;
            8'b1110_1011:  is_jmp     = 1'b1;
            8'b1111_0101:  is_cmc     = 1'b1;
            8'b1111_100?:  is_clc_stc = 1'b1;
            default: ;
        endcase
    end

    // Store address is always a word
    assign imm_wide = is_store | (is_mov_imm ? opcode[3] : opcode[0]);

    // Direction bit picks which modrm field is the destination
    assign dst_sel = opcode[1] ? modrm[5:3] : modrm[2:0];
    assign src_sel = opcode[1] ? modrm[2:0] : modrm[5:3];

    assign jump_ip = ip + 16'd1 + {{8{bus[7]}}, bus};

    assign address = (mode == STORE) ? ({`CORE_RESET_DS, 4'h0} + {4'h0, imm})
                                     : ({`CORE_RESET_CS, 4'h0} + {4'h0, ip});
    assign cond = opcode[3:0];

    // ============================================================
    // Datapath controls
    // ============================================================

    always_comb begin
        rsel_a  = 3'd0;
        rsel_b  = src_sel;
        wsel    = dst_sel;
        wide    = 1'b1;
        we      = 1'b0;
        wdata   = alu_result;
        alu_a   = rdata_a;
        alu_b   = rdata_b;
        alu_op  = alu_op_t'(opcode[5:3]);
        flag_op = FLAG_NONE;
        if (mode == MAIN) begin
            if (is_cmc) begin
                flag_op = FLAG_CMC;
            end else if (is_clc_stc) begin
                flag_op = opcode[0] ? FLAG_STC : FLAG_CLC;
            end
        end else if (mode == WRITEBACK) begin
            if (is_alu_rm) begin
                rsel_a  = dst_sel;
                wide    = opcode[0];
                we      = (alu_op != ALU_CMP);
                flag_op = FLAG_ALL;
            end else if (is_alu_imm) begin
                wsel    = 3'd0;
                wide    = opcode[0];
                alu_b   = imm;
                we      = (alu_op != ALU_CMP);
                flag_op = FLAG_ALL;
            end else if (is_incdec) begin
                rsel_a  = opcode[2:0];
                wsel    = opcode[2:0];
                alu_b   = 16'd1;
                alu_op  = opcode[3] ? ALU_SUB : ALU_ADD;
                we      = 1'b1;
                flag_op = FLAG_NO_CF;
            end else if (is_mov_imm) begin
                wsel  = opcode[2:0];
                wide  = opcode[3];
                wdata = imm;
                we    = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            mode <= PREPARE;
            step <= 1'b0;
            ip   <= '0;
            wreq <= 1'b0;
            data <= '0;
        end else if (locked) begin
            case (mode)
                PREPARE: begin
                    opcode <= bus;
                    // HLT keeps IP on itself and is fetched again
                    if (bus != OP_HLT) begin
                        ip <= ip + 16'd1;
                    end
                    step <= 1'b0;
                    mode <= MAIN;
                end
                MAIN: begin
                    if (is_alu_rm) begin
                        mode <= FETCH_MODRM;
                    end else if (is_alu_imm || is_mov_imm || is_store) begin
                        mode <= IMMEDIATE;
                    end else if (is_incdec) begin
                        mode <= WRITEBACK;
                    end else begin
                        // Displacement byte is on the bus now
                        if (is_jcc || is_jmp) begin
                            ip <= (is_jmp || cond_true) ? jump_ip : ip + 16'd1;
                        end
                        mode <= PREPARE;
                    end
                end
                FETCH_MODRM: begin
                    modrm <= bus;
                    ip    <= ip + 16'd1;
                    mode  <= WRITEBACK;
                end
                IMMEDIATE: begin
                    ip <= ip + 16'd1;
                    if (!step) begin
                        imm <= {8'h00, bus};
                        if (imm_wide) begin
                            step <= 1'b1;
                        end else begin
                            mode <= WRITEBACK;
                        end
                    end else begin
                        imm[15:8] <= bus;
                        step      <= 1'b0;
                        mode      <= WRITEBACK;
                    end
                end
                WRITEBACK: begin
                    if (is_store) begin
                        data <= rdata_a[7:0];
                        wreq <= 1'b1;
                        mode <= STORE;
                    end else begin
                        mode <= PREPARE;
                    end
                end
                STORE: begin
                    // AH follows AL at the next address
                    if (opcode[0] && !step) begin
                        data <= rdata_a[15:8];
                        imm  <= imm + 16'd1;
                        step <= 1'b1;
                    end else begin
                        wreq <= 1'b0;
                        step <= 1'b0;
                        mode <= PREPARE;
                    end
                end
                default: mode <= PREPARE;
            endcase
        end
    end

endmodule

// ==== design/core_top.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_top (
    input  logic                    clock,
    input  logic                    resetn,
    input  logic                    locked,
    output logic [`CORE_ADDR_W-1:0] address,
    input  logic [7:0]              bus,
    output logic [7:0]              data,
    output logic                    wreq
);
    import core_pkg::*;

    logic [2:0]               rsel_a;
    logic [2:0]               rsel_b;
    logic [2:0]               wsel;
    logic                     wide;
    logic                     we;
    logic [`CORE_WORD_W-1:0]  wdata;
    logic [`CORE_WORD_W-1:0]  rdata_a;
    logic [`CORE_WORD_W-1:0]  rdata_b;
    logic [`CORE_WORD_W-1:0]  alu_a;
    logic [`CORE_WORD_W-1:0]  alu_b;
    logic [`CORE_WORD_W-1:0]  alu_result;
    logic [`CORE_FLAGS_W-1:0] flags_result;
    logic [`CORE_FLAGS_W-1:0] flags;
    logic [3:0]               cond;
    logic                     cond_true;
    alu_op_t                  alu_op;
    flag_op_t                 flag_op;

    core_sequencer u_sequencer (
        .clock      (clock),
        .resetn     (resetn),
        .locked     (locked),
        .bus        (bus),
        .address    (address),
        .data       (data),
        .wreq       (wreq),
        .rsel_a     (rsel_a),
        .rsel_b     (rsel_b),
        .wsel       (wsel),
        .wide       (wide),
        .we         (we),
        .wdata      (wdata),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .flag_op    (flag_op),
        .cond       (cond),
        .cond_true  (cond_true)
    );

    core_regfile u_regfile (
        .clock   (clock),
        .resetn  (resetn),
        .locked  (locked),
        .rsel_a  (rsel_a),
        .rsel_b  (rsel_b),
        .wsel    (wsel),
        .wide    (wide),
        .we      (we),
        .wdata   (wdata),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    core_alu u_alu (
        .a            (alu_a),
        .b            (alu_b),
        .op           (alu_op),
        .wide         (wide),
        .carry_in     (flags[`CORE_FLAG_CF]),
        .result       (alu_result),
        .flags_result (flags_result)
    );

    core_flags u_flags (
        .clock        (clock),
        .resetn       (resetn),
        .locked       (locked),
        .flag_op      (flag_op),
        .flags_result (flags_result),
        .cond         (cond),
        .flags        (flags),
        .cond_true    (cond_true)
    );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clock,
    output logic resetn
);

    // 100 ns period
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Reset held for 8 cycles, released on a falling edge
    initial begin
        resetn = 1'b0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;
    end

endmodule

// ==== bench/tb_checker.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module tb_checker (
    input  logic                    clock,
    input  logic                    resetn,
    input  logic                    locked,
    input  logic [`CORE_ADDR_W-1:0] address,
    input  logic [7:0]              data,
    input  logic                    wreq,
    input  logic [7:0]              code [0:1023],
    output logic                    done,
    output int                      errors
);

    logic [15:0]             r [0:7];
    logic                    cf, pf, zf, sf, of;
    logic [`CORE_ADDR_W-1:0] exp_addr [$];
    logic [7:0]              exp_byte [$];
    logic [`CORE_ADDR_W-1:0] hlt_addr;
    logic [`CORE_ADDR_W-1:0] prev_addr;
    logic                    prev_locked;
    logic                    model_ready;
    logic                    model_halted;
    logic                    halted;
    int                      seen;
    int                      value_errors;
    int                      proto_errors;

    function automatic logic [7:0] code_at(input logic [15:0] a);
        return code[a[9:0]];
    endfunction

    function automatic logic [15:0] get_reg(input logic [2:0] s, input logic w);
        if (w) begin
            return r[s];
        end else if (s[2]) begin
            return {8'h00, r[{1'b0, s[1:0]}][15:8]};
        end
        return {8'h00, r[{1'b0, s[1:0]}][7:0]};
    endfunction

    task automatic put_reg(input logic [2:0] s, input logic w, input logic [15:0] v);
        if (w) begin
            r[s] = v;
        end else if (s[2]) begin
            r[{1'b0, s[1:0]}][15:8] = v[7:0];
        end else begin
            r[{1'b0, s[1:0]}][7:0] = v[7:0];
        end
    endtask

    // x86 arithmetic and flag rules at byte or word width
    function automatic logic [15:0] alu_model(input logic [2:0] op, input logic [15:0] a,
                                              input logic [15:0] b, input logic w,
                                              input logic keep_cf);
        logic [16:0] ea;
        logic [16:0] eb;
        logic [16:0] full;
        logic [15:0] res;
        logic        c;
        logic        arith;
        logic        sub;
        logic        ma, mb, mr;
        ea    = w ? {1'b0, a} : {9'h000, a[7:0]};
        eb    = w ? {1'b0, b} : {9'h000, b[7:0]};
        c     = (op == 3'd2 || op == 3'd3) ? cf : 1'b0;
        arith = !(op == 3'd1 || op == 3'd4 || op == 3'd6);
        sub   = (op == 3'd3 || op == 3'd5 || op == 3'd7);
        case (op)
            3'd0, 3'd2: full = ea + eb + {16'h0000, c};
            3'd1:       full = ea | eb;
            3'd4:       full = ea & eb;
            3'd6:       full = ea ^ eb;
            default:    full = ea - eb - {16'h0000, c};
        endcase
        res = w ? full[15:0] : {8'h00, full[7:0]};
        ma  = w ? a[15] : a[7];
        mb  = w ? b[15] : b[7];
        mr  = w ? res[15] : res[7];
        if (!keep_cf) begin
            if (!arith) begin
                cf = 1'b0;
            end else if (sub) begin
                cf = (ea < eb + {16'h0000, c});
            end else begin
                cf = w ? full[16] : full[8];
            end
        end
        of = arith && (sub ? (ma != mb && mr != ma) : (ma == mb && mr != ma));
        zf = (res == 16'h0000);
        sf = mr;
        pf = ~^res[7:0];
        return res;
    endfunction

    function automatic logic cond_model(input logic [3:0] c);
        logic t;
        case (c[3:1])
            3'd0:    t = of;
            3'd1:    t = cf;
            3'd2:    t = zf;
            3'd3:    t = cf | zf;
            3'd4:    t = sf;
            3'd5:    t = pf;
            3'd6:    t = sf ^ of;
            default: t = (sf ^ of) | zf;
        endcase
        return t ^ c[0];
    endfunction

    // ============================================================
    // Instruction-level model
    // ============================================================

    task automatic run_model();
        logic [15:0] ip;
        logic [15:0] res;
        logic [15:0] ea;
        logic [15:0] disp;
        logic [7:0]  op;
        logic [7:0]  mr;
        logic [2:0]  dst;
        logic [2:0]  src;
        logic        w;
        int          steps;
        ip = 16'h0000;
        for (int i = 0; i < 8; i++) begin
            r[i] = 16'h0000;
        end
        {cf, pf, zf, sf, of} = 5'b0;
        model_halted = 1'b0;
        steps = 0;
        while (!model_halted && steps < 2000) begin
            op = code_at(ip);
            steps++;
            casez (op)
                8'b00_???_0??: begin
                    mr  = code_at(ip + 16'd1);
                    ip  = ip + 16'd2;
                    w   = op[0];
                    dst = op[1] ? mr[5:3] : mr[2:0];
                    src = op[1] ? mr[2:0] : mr[5:3];
                    res = alu_model(op[5:3], get_reg(dst, w), get_reg(src, w), w, 1'b0);
                    if (op[5:3] != 3'd7) begin
                        put_reg(dst, w, res);
                    end
                end
                8'b00_???_10?: begin
                    w  = op[0];
                    ea = w ? {code_at(ip + 16'd2), code_at(ip + 16'd1)}
                           : {8'h00, code_at(ip + 16'd1)};
                    ip = ip + (w ? 16'd3 : 16'd2);
                    res = alu_model(op[5:3], get_reg(3'd0, w), ea, w, 1'b0);
                    if (op[5:3] != 3'd7) begin
                        put_reg(3'd0, w, res);
                    end
                end
                8'b0100_????: begin
                    ip  = ip + 16'd1;
                    res = alu_model(op[3] ? 3'd5 : 3'd0, r[op[2:0]], 16'd1, 1'b1, 1'b1);
                    r[op[2:0]] = res;
                end
                8'b1011_????: begin
                    w  = op[3];
                    ea = {code_at(ip + 16'd2), code_at(ip + 16'd1)};
                    ip = ip + (w ? 16'd3 : 16'd2);
                    put_reg(op[2:0], w, ea);
                end
                8'b1010_001?: begin
                    ea = {code_at(ip + 16'd2), code_at(ip + 16'd1)};
                    ip = ip + 16'd3;
                    exp_addr.push_back({`CORE_RESET_DS, 4'h0} + {4'h0, ea});
                    exp_byte.push_back(r[0][7:0]);
                    if (op[0]) begin
                        exp_addr.push_back({`CORE_RESET_DS, 4'h0} + {4'h0, ea + 16'd1});
                        exp_byte.push_back(r[0][15:8]);
                    end
                end
                8'b0111_????, 8'hEB: begin
                    mr   = code_at(ip + 16'd1);
                    disp = {{8{mr[7]}}, mr};
                    ip   = ip + 16'd2;
                    if (op == 8'hEB || cond_model(op[3:0])) begin
                        ip = ip + disp;
                    end
                end
                8'hF5: begin
                    cf = ~cf;
                    ip = ip + 16'd1;
                end
                8'hF8: begin
                    cf = 1'b0;
                    ip = ip + 16'd1;
                end
                8'hF9: begin
                    cf = 1'b1;
                    ip = ip + 16'd1;
                end
                8'hF4: begin
                    hlt_addr     = {`CORE_RESET_CS, 4'h0} + {4'h0, ip};
                    model_halted = 1'b1;
                end
                default: ip = ip + 16'd1;
            endcase
        end
    endtask

    initial begin
        done         = 1'b0;
        errors       = 0;
        seen         = 0;
        value_errors = 0;
        proto_errors = 0;
        model_ready  = 1'b0;
        halted       = 1'b0;
        @(posedge resetn);
        if (address !== {`CORE_RESET_CS, 4'h0} || wreq !== 1'b0) begin
            $display("Error %0t: after reset address %h wreq %b", $time, address, wreq);
            value_errors++;
        end
        run_model();
        if (!model_halted) begin
            $display("The reference model never reached HLT");
            proto_errors++;
        end
        model_ready = 1'b1;
        wait (halted);
        repeat (20) @(posedge clock);
        if (seen != exp_addr.size()) begin
            $display("Error %0t: %0d stores seen, %0d expected", $time, seen, exp_addr.size());
            proto_errors++;
        end
        $display("Checker: %0d of %0d stores, %0d value errors, %0d protocol errors",
                 seen, exp_addr.size(), value_errors, proto_errors);
        errors = value_errors + proto_errors;
        done   = 1'b1;
    end

    // Pre-edge values of the DUT outputs
    always @(posedge clock) begin
        if (resetn && model_ready) begin
            if (!prev_locked && address != prev_addr) begin
                $display("Error %0t: address moved while locked was low", $time);
                proto_errors++;
            end
            if (wreq && locked) begin
                if (seen >= exp_addr.size()) begin
                    $display("Error %0t: unexpected store %h to %h", $time, data, address);
                    proto_errors++;
                end else if (address != exp_addr[seen] || data != exp_byte[seen]) begin
                    $display("Error %0t: store %0d got %h at %h, expected %h at %h", $time,
                             seen, data, address, exp_byte[seen], exp_addr[seen]);
                    value_errors++;
                end
                seen++;
            end
            if (address == hlt_addr) begin
                halted = 1'b1;
            end else if (halted) begin
                $display("Error %0t: address %h left the HLT byte", $time, address);
                proto_errors++;
            end
        end
        prev_addr   = address;
        prev_locked = locked;
    end

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module tb_top;

    localparam int NUM_INSTR      = 200;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 12 * 4;

    logic                    clock;
    logic                    resetn;
    logic                    locked;
    logic [`CORE_ADDR_W-1:0] address;
    logic [7:0]              bus;
    logic [7:0]              data;
    logic                    wreq;
    logic                    done;
    int                      errors;

    logic [7:0]  code [0:1023];
    logic [31:0] lfsr_state;

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    tb_clock u_clock (
        .clock  (clock),
        .resetn (resetn)
    );

    core_top u_dut (
        .clock   (clock),
        .resetn  (resetn),
        .locked  (locked),
        .address (address),
        .bus     (bus),
        .data    (data),
        .wreq    (wreq)
    );

    tb_checker u_checker (
        .clock   (clock),
        .resetn  (resetn),
        .locked  (locked),
        .address (address),
        .data    (data),
        .wreq    (wreq),
        .code    (code),
        .done    (done),
        .errors  (errors)
    );

    // ============================================================
    // Random program
    // ============================================================

    initial begin
        int   pc;
        int   kind;
        int   tgt;
        int   start [0:NUM_INSTR-1];
        int   jpos [$];
        int   jtgt [$];
        logic w;
        locked     = 1'b0;
        bus        = 8'h00;
        lfsr_state = 32'hc7dd;
        for (int i = 0; i < 1024; i++) begin
            code[i] = 8'(i ^ (i >> 5));
        end
        pc = 0;
        for (int n = 0; n < NUM_INSTR - 1; n++) begin
            start[n] = pc;
            kind = int'(rand_bits(4));
            w = 1'(rand_bits(1));
            case (kind)
                0, 1, 2: begin
                    code[pc]     = {2'b00, 3'(rand_bits(3)), 1'b0, 2'(rand_bits(2))};
                    code[pc + 1] = 8'(rand_bits(8));
                    pc += 2;
                end
                3, 4: begin
                    code[pc]     = {2'b00, 3'(rand_bits(3)), 2'b10, w};
                    code[pc + 1] = 8'(rand_bits(8));
                    code[pc + 2] = 8'(rand_bits(8));
                    pc += w ? 3 : 2;
                end
                5: begin
                    code[pc] = {4'b0100, 4'(rand_bits(4))};
                    pc += 1;
                end
                6, 7: begin
                    code[pc]     = {4'b1011, w, 3'(rand_bits(3))};
                    code[pc + 1] = 8'(rand_bits(8));
                    code[pc + 2] = 8'(rand_bits(8));
                    pc += w ? 3 : 2;
                end
                11, 12, 13: begin
                    code[pc] = (kind == 13) ? 8'hEB : {4'b0111, 4'(rand_bits(4))};
                    // Forward to one of the next few instruction starts
                    tgt = n + 1 + int'(rand_bits(2));
                    if (tgt > NUM_INSTR - 1) begin
                        tgt = NUM_INSTR - 1;
                    end
                    jpos.push_back(pc + 1);
                    jtgt.push_back(tgt);
                    pc += 2;
                end
                14: begin
                    kind = int'(rand_bits(2));
                    code[pc] = (kind == 0) ? 8'hF5 : (kind == 1) ? 8'hF8 : 8'hF9;
                    pc += 1;
                end
                default: begin
                    code[pc]     = {7'b1010001, w};
                    code[pc + 1] = 8'(rand_bits(8));
                    code[pc + 2] = 8'(rand_bits(8));
                    pc += 3;
                end
            endcase
        end
        start[NUM_INSTR - 1] = pc;
        code[pc] = 8'hF4;
        for (int k = 0; k < jpos.size(); k++) begin
            code[jpos[k]] = 8'(start[jtgt[k]] - jpos[k] - 1);
        end
    end

    // Memory answer and back-pressure, both on the falling edge
    always @(negedge clock) begin
        // Code window at F0000
        bus    <= (address[19:10] == 10'h3C0) ? code[address[9:0]] : 8'h00;
        locked <= (rand_bits(1) != 16'd0);
    end

    initial begin
        wait (done);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * 100 + 1000);
        $display("Timeout: the DUT did not reach HLT and finish its stores in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+design
design/core_pkg.sv
design/core_alu.sv
design/core_regfile.sv
design/core_flags.sv
design/core_sequencer.sv
design/core_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_top -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0
